//--- filelist.f
+incdir+include
hw/sqPkg.sv
hw/rangeMaskGen.sv
hw/storeQueue.sv
hw/storeForward.sv
hw/storeDrain.sv
hw/storeUnit.sv
tb/storeUnitTb.sv

//--- hw/rangeMaskGen.sv
`timescale 1ns/1ps
`default_nettype none

module rangeMaskGen #(
    parameter int numEntries = 16,
    parameter int inclusiveEnd = 0
) (
    input wire [$clog2(numEntries)-1:0] startIdx,
    input wire [$clog2(numEntries)-1:0] endIdx,
    input wire allOnes,
    input wire enable,
    output logic [numEntries-1:0] range
);

    always_comb begin
        logic afterStart;
        logic beforeEnd;
        for (int i = 0; i < numEntries; i++) begin
            afterStart = (i >= int'(startIdx));
            if (inclusiveEnd != 0)
                beforeEnd = (i <= int'(endIdx));
            else
                beforeEnd = (i < int'(endIdx));

            if (!enable)
                range[i] = 1'b0;
            else if (allOnes)
                range[i] = 1'b1;
            else if (startIdx <= endIdx)
                range[i] = afterStart && beforeEnd;
            else
                // Range wraps past the top
                range[i] = afterStart || beforeEnd;
        end
    end

endmodule

`default_nettype wire

//--- hw/sqPkg.sv
`default_nettype none
`include "sq_cfg.svh"

package sqPkg;

    typedef logic [`SQN_BITS-1:0] SqN;

    // From address generation
    typedef struct packed {
        logic valid;
        SqN storeSqN;
        logic [31:0] addr;
        logic [3:0] wmask;
    } StAddrOp;

    typedef struct packed {
        logic valid;
        SqN storeSqN;
        logic [31:0] data;
    } StDataOp;

    // storeSqN is the youngest store older than the load
    typedef struct packed {
        logic valid;
        SqN storeSqN;
        logic [31:0] addr;
        logic [1:0] size;
    } LdLookup;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
        logic [3:0] mask;
        logic conflict;
    } FwdResult;

    // storeSqN is the last store that survives
    typedef struct packed {
        logic taken;
        SqN storeSqN;
    } BranchInfo;

    typedef struct packed {
        logic [29:0] addr;
        logic [3:0] wmask;
        logic [31:0] data;
        logic addrAvail;
        logic loaded;
    } SqEntry;

    // Store on its way to the cache
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
    } SqOut;

endpackage

`default_nettype wire

//--- hw/storeDrain.sv
`timescale 1ns/1ps
`default_nettype none

module storeDrain (
    input wire clk,
    input wire rst,
    input wire sqPkg::SqEntry headEntry,
    input wire headReady,
    input wire stall,
    output sqPkg::SqOut storeOut,
    output logic pop
);
    import sqPkg::*;

    logic outFree;

    // Register is empty or being taken by the cache
    assign outFree = !storeOut.valid || !stall;

    assign pop = headReady && outFree;

    always_ff @(posedge clk) begin
        if (rst) begin
            storeOut.valid <= 1'b0;
        end else if (outFree) begin
            storeOut <= SqOut'{
                valid: headReady,
                addr: {headEntry.addr, 2'b00},
                data: headEntry.data,
                wmask: headEntry.wmask
            };
        end
    end

endmodule

`default_nettype wire

//--- hw/storeForward.sv
`timescale 1ns/1ps
`default_nettype none
`include "sq_cfg.svh"

module storeForward (
    input wire clk,
    input wire rst,
    input wire sqPkg::LdLookup ldLookup,
    input wire sqPkg::SqEntry entries[`SQ_SIZE],
    input wire sqPkg::SqN baseIndex,
    input wire [`SQ_SIZE-1:0] readyMask,
    input wire sqPkg::SqOut drainOut,
    output sqPkg::FwdResult fwd
);
    import sqPkg::*;

    SqN ldDist;
    logic [`SQ_SIZE-1:0] olderMask;
    logic [3:0] readMask;
    logic [31:0] mergeData;
    logic [3:0] mergeMask;
    logic conflict;

    assign ldDist = ldLookup.storeSqN - baseIndex;

    // Stores from the head up to the load's SqN
    rangeMaskGen #(
        .numEntries(`SQ_SIZE),
        .inclusiveEnd(1)
    ) olderRangeGen (
        .startIdx(baseIndex[`SQ_IDX_BITS-1:0]),
        .endIdx(ldLookup.storeSqN[`SQ_IDX_BITS-1:0]),
        .allOnes($signed(ldDist) >= (`SQ_SIZE - 1)),
        .enable($signed(ldDist) >= 0),
        .range(olderMask)
    );

    always_comb begin
        case (ldLookup.size)
            2'd0: readMask = 4'b0001 << ldLookup.addr[1:0];
            2'd1: readMask = ldLookup.addr[1] ? 4'b1100 : 4'b0011;
            default: readMask = 4'b1111;
        endcase
    end

    always_comb begin
        logic [`SQ_IDX_BITS-1:0] idx;
        logic hit;
        mergeData = '0;
        // Unread bytes count as covered
        mergeMask = ~readMask;
        conflict = 1'b0;

        // Drain register holds the oldest store
        if (drainOut.valid && drainOut.addr[31:2] == ldLookup.addr[31:2]) begin
            for (int b = 0; b < 4; b++)
                if (drainOut.wmask[b])
                    mergeData[b*8 +: 8] = drainOut.data[b*8 +: 8];
            mergeMask = mergeMask | drainOut.wmask;
        end

        // Walk oldest to youngest so younger bytes win
        for (int k = 0; k < `SQ_SIZE; k++) begin
            idx = baseIndex[`SQ_IDX_BITS-1:0] + k[`SQ_IDX_BITS-1:0];
            hit = entries[idx].addrAvail && (olderMask[idx] || readyMask[idx]) &&
                entries[idx].addr == ldLookup.addr[31:2];
            if (hit && entries[idx].loaded) begin
                for (int b = 0; b < 4; b++)
                    if (entries[idx].wmask[b])
                        mergeData[b*8 +: 8] = entries[idx].data[b*8 +: 8];
                mergeMask = mergeMask | entries[idx].wmask;
            end else if (hit && (entries[idx].wmask & readMask) != 4'b0000) begin
                conflict = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            fwd.valid <= 1'b0;
        else
            fwd.valid <= ldLookup.valid;

        if (ldLookup.valid) begin
            fwd.data <= mergeData;
            fwd.mask <= mergeMask;
            fwd.conflict <= conflict;
        end
    end

endmodule

`default_nettype wire

//--- hw/storeQueue.sv
`timescale 1ns/1ps
`default_nettype none
`include "sq_cfg.svh"

module storeQueue (
    input wire clk,
    input wire rst,
    input wire sqPkg::StAddrOp stAddr,
    input wire sqPkg::StDataOp stData,
    input wire sqPkg::SqN comStSqN,
    input wire sqPkg::BranchInfo branch,
    input wire pop,
    output sqPkg::SqEntry entries[`SQ_SIZE],
    output sqPkg::SqN baseIndex,
    output logic [`SQ_SIZE-1:0] readyMask,
    output sqPkg::SqEntry headEntry,
    output logic headReady,
    output logic empty,
    output sqPkg::SqN maxStoreSqN
);
    import sqPkg::*;

    localparam SqN sqSize = SqN'(`SQ_SIZE);

    SqN nextBase;
    SqN branchDist;
    SqN branchFirst;
    SqN addrAge;
    SqN dataAge;
    logic [`SQ_IDX_BITS-1:0] headIdx;
    logic [`SQ_SIZE-1:0] readyNext;
    logic [`SQ_SIZE-1:0] invalMask;
    logic addrWrite;
    logic dataWrite;
    logic anyAvail;

    assign headIdx = baseIndex[`SQ_IDX_BITS-1:0];
    assign nextBase = baseIndex + SqN'(pop);
    assign headEntry = entries[headIdx];
    assign headReady = readyMask[headIdx] && entries[headIdx].loaded;

    // Committed range from the head up to comStSqN
    rangeMaskGen #(
        .numEntries(`SQ_SIZE),
        .inclusiveEnd(0)
    ) readyRangeGen (
        .startIdx(nextBase[`SQ_IDX_BITS-1:0]),
        .endIdx(comStSqN[`SQ_IDX_BITS-1:0]),
        .allOnes(SqN'(comStSqN - nextBase) == sqSize),
        .enable(1'b1),
        .range(readyNext)
    );

    // Entries after the branch store, up to the end of the ring
    assign branchDist = branch.storeSqN - baseIndex;
    assign branchFirst = branch.storeSqN + SqN'(1);

    rangeMaskGen #(
        .numEntries(`SQ_SIZE),
        .inclusiveEnd(0)
    ) invalRangeGen (
        .startIdx(branchFirst[`SQ_IDX_BITS-1:0]),
        .endIdx(headIdx),
        .allOnes($signed(branchDist) < 0),
        .enable(branch.taken && $signed(branchDist) < (`SQ_SIZE - 1)),
        .range(invalMask)
    );

    // Writes younger than a taken branch are dropped
    assign addrAge = stAddr.storeSqN - branch.storeSqN;
    assign dataAge = stData.storeSqN - branch.storeSqN;
    assign addrWrite = stAddr.valid && (!branch.taken || $signed(addrAge) <= 0);
    assign dataWrite = stData.valid && (!branch.taken || $signed(dataAge) <= 0);

    always_comb begin
        anyAvail = 1'b0;
        for (int i = 0; i < `SQ_SIZE; i++)
            if (entries[i].addrAvail)
                anyAvail = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            baseIndex <= '0;
            readyMask <= '0;
            empty <= 1'b1;
            maxStoreSqN <= sqSize - SqN'(1);
            for (int i = 0; i < `SQ_SIZE; i++) begin
                entries[i].addrAvail <= 1'b0;
                entries[i].loaded <= 1'b0;
            end
        end else begin
            if (pop) begin
                entries[headIdx].addrAvail <= 1'b0;
                entries[headIdx].loaded <= 1'b0;
            end

            if (dataWrite) begin
                entries[stData.storeSqN[`SQ_IDX_BITS-1:0]].data <= stData.data;
                entries[stData.storeSqN[`SQ_IDX_BITS-1:0]].loaded <= 1'b1;
            end

            if (addrWrite) begin
                entries[stAddr.storeSqN[`SQ_IDX_BITS-1:0]].addr <= stAddr.addr[31:2];
                entries[stAddr.storeSqN[`SQ_IDX_BITS-1:0]].wmask <= stAddr.wmask;
                entries[stAddr.storeSqN[`SQ_IDX_BITS-1:0]].addrAvail <= 1'b1;
            end

            // Branch wins over writes in the same cycle
            for (int i = 0; i < `SQ_SIZE; i++) begin
                if (invalMask[i]) begin
                    entries[i].addrAvail <= 1'b0;
                    entries[i].loaded <= 1'b0;
                end
            end

            baseIndex <= nextBase;
            readyMask <= readyNext;
            empty <= !anyAvail && !addrWrite;
            maxStoreSqN <= nextBase + sqSize - SqN'(1);
        end
    end

endmodule

`default_nettype wire

//--- hw/storeUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "sq_cfg.svh"

module storeUnit (
    input wire clk,
    input wire rst,
    input wire sqPkg::StAddrOp stAddr,
    input wire sqPkg::StDataOp stData,
    input wire sqPkg::LdLookup ldLookup,
    input wire sqPkg::SqN comStSqN,
    input wire sqPkg::BranchInfo branch,
    input wire stall,
    output sqPkg::FwdResult fwd,
    output sqPkg::SqOut storeOut,
    output logic empty,
    output sqPkg::SqN maxStoreSqN
);
    import sqPkg::*;

    SqEntry entries[`SQ_SIZE];
    SqN baseIndex;
    logic [`SQ_SIZE-1:0] readyMask;
    SqEntry headEntry;
    logic headReady;
    logic pop;

    storeQueue i_storeQueue (
        .clk(clk),
        .rst(rst),
        .stAddr(stAddr),
        .stData(stData),
        .comStSqN(comStSqN),
        .branch(branch),
        .pop(pop),
        .entries(entries),
        .baseIndex(baseIndex),
        .readyMask(readyMask),
        .headEntry(headEntry),
        .headReady(headReady),
        .empty(empty),
        .maxStoreSqN(maxStoreSqN)
    );

    storeForward i_storeForward (
        .clk(clk),
        .rst(rst),
        .ldLookup(ldLookup),
        .entries(entries),
        .baseIndex(baseIndex),
        .readyMask(readyMask),
        .drainOut(storeOut),
        .fwd(fwd)
    );

    storeDrain i_storeDrain (
        .clk(clk),
        .rst(rst),
        .headEntry(headEntry),
        .headReady(headReady),
        .stall(stall),
        .storeOut(storeOut),
        .pop(pop)
    );

endmodule

`default_nettype wire

//--- include/sq_cfg.svh
`ifndef SQ_CFG_SVH
`define SQ_CFG_SVH

// Number of queue entries, power of two
`define SQ_SIZE 16

// Entry index width
`define SQ_IDX_BITS 4

// Index plus a wrap bit for age compares
`define SQN_BITS 5

`endif

//--- tb/storeUnitTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "sq_cfg.svh"

module storeUnitTb;
    import sqPkg::*;

    // Six short tests, the longest streams 40 stores
    localparam int maxCycles = 2000;

    logic clk;
    logic rst;
    StAddrOp stAddr;
    StDataOp stData;
    LdLookup ldLookup;
    SqN comStSqN;
    BranchInfo branch;
    logic stall;
    FwdResult fwd;
    SqOut storeOut;
    logic empty;
    SqN maxStoreSqN;

    logic [31:0] lfsr;
    logic [31:0] mAddr[64];
    logic [3:0] mMask[64];
    logic [31:0] mData[64];
    // Stores expected on storeOut, oldest first
    SqOut expQ[$];
    int errors;
    int testsRun;
    int drained;
    int cycles;

    storeUnit i_storeUnit (
        .clk(clk),
        .rst(rst),
        .stAddr(stAddr),
        .stData(stData),
        .ldLookup(ldLookup),
        .comStSqN(comStSqN),
        .branch(branch),
        .stall(stall),
        .fwd(fwd),
        .storeOut(storeOut),
        .empty(empty),
        .maxStoreSqN(maxStoreSqN)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= maxCycles) begin
            $display("Timeout after %0d cycles with %0d errors", cycles, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // A store is taken by the cache at the edge where it is valid and not stalled
    always @(negedge clk) begin
        if (!rst && storeOut.valid) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("Store to %h left the queue with none expected at %0t",
                    storeOut.addr, $time);
            end else begin
                if (storeOut.addr != expQ[0].addr || storeOut.data != expQ[0].data ||
                        storeOut.wmask != expQ[0].wmask) begin
                    errors++;
                    $display("FAIL %0t: storeOut %h/%h/%b, expected %h/%h/%b", $time,
                        storeOut.addr, storeOut.data, storeOut.wmask,
                        expQ[0].addr, expQ[0].data, expQ[0].wmask);
                end
                if (maxStoreSqN != SqN'(drained + `SQ_SIZE)) begin
                    errors++;
                    $display("FAIL %0t: maxStoreSqN %0d, expected %0d", $time,
                        maxStoreSqN, SqN'(drained + `SQ_SIZE));
                end
                if (!stall) begin
                    void'(expQ.pop_front());
                    drained++;
                end
            end
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic newStore(input int seq);
        mAddr[seq] = randBits(32) & 32'hffff_fffc;
        mMask[seq] = randBits(4);
        if (mMask[seq] == 4'b0000)
            mMask[seq] = 4'b1111;
        mData[seq] = randBits(32);
    endtask

    task automatic expectStore(input int seq);
        expQ.push_back('{valid: 1'b1, addr: mAddr[seq], data: mData[seq], wmask: mMask[seq]});
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic resetDut();
        rst = 1'b1;
        stAddr = '0;
        stData = '0;
        ldLookup = '0;
        comStSqN = '0;
        branch = '0;
        stall = 1'b0;
        repeat (4) nextCycle();
        expQ.delete();
        drained = 0;
        rst = 1'b0;
    endtask

    // Negative SqN leaves that port idle
    task automatic writeOps(input int aSeq, input int dSeq);
        if (aSeq >= 0)
            stAddr = '{valid: 1'b1, storeSqN: SqN'(aSeq), addr: mAddr[aSeq],
                wmask: mMask[aSeq]};
        if (dSeq >= 0)
            stData = '{valid: 1'b1, storeSqN: SqN'(dSeq), data: mData[dSeq]};
        nextCycle();
        stAddr.valid = 1'b0;
        stData.valid = 1'b0;
    endtask

    task automatic checkLookup(input int sq, input logic [31:0] addr, input logic [1:0] size,
            input logic [31:0] expData, input logic [3:0] dataBytes,
            input logic [3:0] expMask, input logic expConflict);
        logic dataOk;
        ldLookup = '{valid: 1'b1, storeSqN: SqN'(sq), addr: addr, size: size};
        nextCycle();
        ldLookup.valid = 1'b0;
        dataOk = 1'b1;
        for (int b = 0; b < 4; b++)
            if (dataBytes[b] && fwd.data[b*8 +: 8] != expData[b*8 +: 8])
                dataOk = 1'b0;
        if (!fwd.valid || !dataOk || fwd.mask != expMask || fwd.conflict != expConflict) begin
            errors++;
            $display("FAIL %0t: load %h sq %0d got v%b %h/%b c%b, expected %h/%b c%b", $time,
                addr, sq, fwd.valid, fwd.data, fwd.mask, fwd.conflict,
                expData, expMask, expConflict);
        end
    endtask

    task automatic waitDrained(input int limit);
        int n;
        n = 0;
        while (expQ.size() != 0 && n < limit) begin
            nextCycle();
            n++;
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("Stores did not drain, %0d still missing at %0t", expQ.size(), $time);
        end
        repeat (3) nextCycle();
    endtask

    task automatic testReset();
        testsRun++;
        resetDut();
        if (!empty || storeOut.valid || fwd.valid || maxStoreSqN != SqN'(15)) begin
            errors++;
            $display("FAIL %0t: after reset empty %b out %b fwd %b max %0d", $time,
                empty, storeOut.valid, fwd.valid, maxStoreSqN);
        end
    endtask

    task automatic testDrainOrder();
        int aOrder[6];
        int dOrder[6];
        testsRun++;
        resetDut();
        aOrder = '{3, 0, 5, 1, 4, 2};
        dOrder = '{1, 5, 0, 2, 3, 4};
        for (int i = 0; i < 6; i++)
            newStore(i);
        for (int i = 0; i < 6; i++)
            writeOps(aOrder[i], dOrder[i]);
        if (empty) begin
            errors++;
            $display("FAIL %0t: empty high with six stores queued", $time);
        end
        for (int i = 0; i < 6; i++)
            expectStore(i);
        comStSqN = SqN'(6);
        waitDrained(100);
        if (maxStoreSqN != SqN'(6 + `SQ_SIZE - 1) || !empty) begin
            errors++;
            $display("FAIL %0t: after drain max %0d empty %b", $time, maxStoreSqN, empty);
        end
    endtask

    task automatic testForward();
        logic [31:0] d0;
        logic [31:0] d1;
        testsRun++;
        resetDut();
        for (int i = 0; i < 3; i++)
            newStore(i);
        mAddr[1] = mAddr[0];
        mAddr[2] = mAddr[0];
        mMask[0] = 4'b0011;
        mMask[1] = 4'b0110;
        mMask[2] = 4'b1000;
        d0 = mData[0];
        d1 = mData[1];
        writeOps(0, 0);
        writeOps(1, 1);
        // Store 2 has its address but no data yet
        writeOps(2, -1);
        checkLookup(1, mAddr[0], 2'd2, {8'h00, d1[23:8], d0[7:0]}, 4'b0111, 4'b0111, 1'b0);
        checkLookup(1, mAddr[0] + 2, 2'd1, {8'h00, d1[23:16], 16'h0000}, 4'b0100,
            4'b0111, 1'b0);
        checkLookup(2, mAddr[0], 2'd2, {8'h00, d1[23:8], d0[7:0]}, 4'b0111, 4'b0111, 1'b1);
        checkLookup(0, mAddr[0], 2'd2, {16'h0000, d0[15:0]}, 4'b0011, 4'b0011, 1'b0);
    endtask

    task automatic testBranch();
        testsRun++;
        resetDut();
        for (int i = 0; i < 8; i++)
            newStore(i);
        for (int i = 0; i < 8; i++)
            writeOps(i, i);
        branch = '{taken: 1'b1, storeSqN: SqN'(3)};
        nextCycle();
        branch.taken = 1'b0;
        for (int i = 0; i < 4; i++)
            expectStore(i);
        comStSqN = SqN'(8);
        waitDrained(100);
        if (!empty) begin
            errors++;
            $display("FAIL %0t: empty low after branch and drain", $time);
        end
        checkLookup(7, mAddr[5], 2'd2, 32'h0, 4'b0000, 4'b0000, 1'b0);
    endtask

    task automatic testStall();
        testsRun++;
        resetDut();
        stall = 1'b1;
        for (int i = 0; i < 5; i++) begin
            newStore(i);
            writeOps(i, i);
            expectStore(i);
        end
        comStSqN = SqN'(5);
        repeat (8) nextCycle();
        if (!storeOut.valid || storeOut.addr != mAddr[0] || storeOut.data != mData[0]) begin
            errors++;
            $display("FAIL %0t: storeOut %b %h under stall, expected %h", $time,
                storeOut.valid, storeOut.addr, mAddr[0]);
        end
        stall = 1'b0;
        waitDrained(100);
    endtask

    task automatic testWrap();
        SqN room;
        testsRun++;
        resetDut();
        for (int k = 0; k < 40; k++) begin
            newStore(k);
            room = SqN'(k) - maxStoreSqN;
            while ($signed(room) > 0) begin
                nextCycle();
                room = SqN'(k) - maxStoreSqN;
            end
            if (k > 0)
                comStSqN = SqN'(k - 1);
            writeOps(k, k);
            expectStore(k);
        end
        comStSqN = SqN'(40);
        waitDrained(200);
        if (!empty || maxStoreSqN != SqN'(40 + `SQ_SIZE - 1)) begin
            errors++;
            $display("FAIL %0t: after wrap empty %b max %0d", $time, empty, maxStoreSqN);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        stAddr = '0;
        stData = '0;
        ldLookup = '0;
        comStSqN = '0;
        branch = '0;
        stall = 1'b0;
        errors = 0;
        testsRun = 0;
        drained = 0;
        cycles = 0;
        lfsr = 32'h39401bea;
        testReset();
        testDrainOrder();
        testForward();
        testBranch();
        testStall();
        testWrap();
        $display("Tests run: %0d, errors: %0d", testsRun, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
